// ==== verilog/axi_cfg.svh ====
`ifndef AXI_CFG_SVH
`define AXI_CFG_SVH

// transaction id width
`define AXI_ID_W        4

// byte address width
`define AXI_ADDR_W      64

// data beat width, strobes follow at one bit per byte
`define AXI_DATA_W      64
`define AXI_STRB_W      (`AXI_DATA_W / 8)

// burst length minus one
`define AXI_LEN_W       8

// beat size code
`define AXI_SIZE_W      3

// burst kind (fixed, incr, wrap)
`define AXI_BURST_W     2

// response code
`define AXI_RESP_W      2

// number of slaves behind the router
`define AXI_SLAVE_NUM   2

`endif

// ==== verilog/axi_pkg.sv ====
`include "axi_cfg.svh"

package axi_pkg;

    // transaction id
    typedef logic [`AXI_ID_W-1:0]    id_t;

    // byte address
    typedef logic [`AXI_ADDR_W-1:0]  addr_t;

    // one data beat and its byte strobes
    typedef logic [`AXI_DATA_W-1:0]  data_t;
    typedef logic [`AXI_STRB_W-1:0]  strb_t;

    // burst length minus one
    typedef logic [`AXI_LEN_W-1:0]   len_t;

    // beat size code, log2 of bytes per beat
    typedef logic [`AXI_SIZE_W-1:0]  size_t;

    // burst kind
    typedef logic [`AXI_BURST_W-1:0] burst_t;

    // B and R response code
    typedef logic [`AXI_RESP_W-1:0]  resp_t;

    // normal access success
    localparam resp_t RESP_OKAY = 2'b00;

endpackage

// ==== verilog/route_pkg.sv ====
`include "axi_cfg.svh"

package route_pkg;

    import axi_pkg::*;

    // one select bit per slave, lowest set bit wins
    typedef logic [`AXI_SLAVE_NUM-1:0] slave_sel_t;

    // response returned by the default sink when nothing is selected
    localparam id_t   DEFAULT_ID   = '0;
    localparam data_t DEFAULT_DATA = '0;
    localparam resp_t DEFAULT_RESP = RESP_OKAY;

endpackage

// ==== verilog/axi_write_if.sv ====
`timescale 1ns/1ns

interface axi_write_if;

    import axi_pkg::*;

    // write address channel
    id_t    aw_id;
    addr_t  aw_addr;
    len_t   aw_len;
    size_t  aw_size;
    burst_t aw_burst;
    logic   aw_valid;
    logic   aw_ready;

    // write data channel
    data_t  w_data;
    strb_t  w_strb;
    logic   w_last;
    logic   w_valid;
    logic   w_ready;

    // write response channel
    id_t    b_id;
    resp_t  b_resp;
    logic   b_valid;
    logic   b_ready;

    modport master (
        output aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_valid,
        output w_data, w_strb, w_last, w_valid,
        output b_ready,
        input  aw_ready, w_ready, b_id, b_resp, b_valid
    );

    modport slave (
        input  aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_valid,
        input  w_data, w_strb, w_last, w_valid,
        input  b_ready,
        output aw_ready, w_ready, b_id, b_resp, b_valid
    );

endinterface

// ==== verilog/axi_read_if.sv ====
`timescale 1ns/1ns

interface axi_read_if;

    import axi_pkg::*;

    // read address channel
    id_t    ar_id;
    addr_t  ar_addr;
    len_t   ar_len;
    size_t  ar_size;
    burst_t ar_burst;
    logic   ar_valid;
    logic   ar_ready;

    // read data channel
    id_t    r_id;
    data_t  r_data;
    resp_t  r_resp;
    logic   r_last;
    logic   r_valid;
    logic   r_ready;

    modport master (
        output ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_valid,
        output r_ready,
        input  ar_ready, r_id, r_data, r_resp, r_last, r_valid
    );

    modport slave (
        input  ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_valid,
        input  r_ready,
        output ar_ready, r_id, r_data, r_resp, r_last, r_valid
    );

endinterface

// ==== verilog/axi_write_router.sv ====
`timescale 1ns/1ns
`include "axi_cfg.svh"

module axi_write_router (
    input  logic                  clk,
    input  logic                  rst,
    input  route_pkg::slave_sel_t write_sel,
    axi_write_if.slave            mst,
    axi_write_if.master           slv [`AXI_SLAVE_NUM]
);

    import axi_pkg::*;
    import route_pkg::*;

    // one-hot grant, only the lowest set select bit survives
    slave_sel_t grant;

    // slave side responses gathered into arrays for the master mux
    logic  [`AXI_SLAVE_NUM-1:0] aw_ready_s;
    logic  [`AXI_SLAVE_NUM-1:0] w_ready_s;
    id_t   [`AXI_SLAVE_NUM-1:0] b_id_s;
    resp_t [`AXI_SLAVE_NUM-1:0] b_resp_s;
    logic  [`AXI_SLAVE_NUM-1:0] b_valid_s;

    // nothing is granted while in reset, so the default sink answers
    assign grant = rst ? '0 : (write_sel & (~write_sel + slave_sel_t'(1)));

    for (genvar k = 0; k < `AXI_SLAVE_NUM; k = k + 1) begin : g_slv
        // select bits below slave k, any of them set takes priority
        localparam slave_sel_t LOWER = slave_sel_t'((1 << k) - 1);

        // requests reach slave k only when it holds the grant
        assign slv[k].aw_id    = grant[k] ? mst.aw_id    : '0;
        assign slv[k].aw_addr  = grant[k] ? mst.aw_addr  : '0;
        assign slv[k].aw_len   = grant[k] ? mst.aw_len   : '0;
        assign slv[k].aw_size  = grant[k] ? mst.aw_size  : '0;
        assign slv[k].aw_burst = grant[k] ? mst.aw_burst : '0;
        assign slv[k].aw_valid = grant[k] & mst.aw_valid;
        assign slv[k].w_data   = grant[k] ? mst.w_data   : '0;
        assign slv[k].w_strb   = grant[k] ? mst.w_strb   : '0;
        assign slv[k].w_last   = grant[k] & mst.w_last;
        assign slv[k].w_valid  = grant[k] & mst.w_valid;
        assign slv[k].b_ready  = grant[k] & mst.b_ready;

        assign aw_ready_s[k] = slv[k].aw_ready;
        assign w_ready_s[k]  = slv[k].w_ready;
        assign b_id_s[k]     = slv[k].b_id;
        assign b_resp_s[k]   = slv[k].b_resp;
        assign b_valid_s[k]  = slv[k].b_valid;

        // a slave that lost arbitration or sits in reset never sees a request
        a_unsel_quiet : assert property (@(posedge clk)
            (rst || !write_sel[k] || ((write_sel & LOWER) != '0))
            |-> (!slv[k].aw_valid && !slv[k].w_valid));
    end

    always_comb begin
        // default sink accepts every beat and answers OKAY at once
        mst.aw_ready = 1'b1;
        mst.w_ready  = 1'b1;
        mst.b_id     = DEFAULT_ID;
        mst.b_resp   = DEFAULT_RESP;
        mst.b_valid  = 1'b1;
        for (int i = 0; i < `AXI_SLAVE_NUM; i++) begin
            if (grant[i]) begin
                mst.aw_ready = aw_ready_s[i];
                mst.w_ready  = w_ready_s[i];
                mst.b_id     = b_id_s[i];
                mst.b_resp   = b_resp_s[i];
                mst.b_valid  = b_valid_s[i];
            end
        end
    end

    // with no select the master is never stalled on AW
    a_sink_ready : assert property (@(posedge clk)
        (write_sel == '0) |-> mst.aw_ready);

endmodule

// ==== verilog/axi_read_router.sv ====
`timescale 1ns/1ns
`include "axi_cfg.svh"

module axi_read_router (
    input  logic                  clk,
    input  logic                  rst,
    input  route_pkg::slave_sel_t read_sel,
    axi_read_if.slave             mst,
    axi_read_if.master            slv [`AXI_SLAVE_NUM]
);

    import axi_pkg::*;
    import route_pkg::*;

    // one-hot grant of the lowest set select bit
    slave_sel_t grant;

    // per slave read responses for the master mux
    logic  [`AXI_SLAVE_NUM-1:0] ar_ready_s;
    id_t   [`AXI_SLAVE_NUM-1:0] r_id_s;
    data_t [`AXI_SLAVE_NUM-1:0] r_data_s;
    resp_t [`AXI_SLAVE_NUM-1:0] r_resp_s;
    logic  [`AXI_SLAVE_NUM-1:0] r_last_s;
    logic  [`AXI_SLAVE_NUM-1:0] r_valid_s;

    assign grant = rst ? '0 : (read_sel & (~read_sel + slave_sel_t'(1)));

    for (genvar k = 0; k < `AXI_SLAVE_NUM; k = k + 1) begin : g_slv
        localparam slave_sel_t LOWER = slave_sel_t'((1 << k) - 1);

        // AR fields and R ready pass only to the granted slave
        assign slv[k].ar_id    = grant[k] ? mst.ar_id    : '0;
        assign slv[k].ar_addr  = grant[k] ? mst.ar_addr  : '0;
        assign slv[k].ar_len   = grant[k] ? mst.ar_len   : '0;
        assign slv[k].ar_size  = grant[k] ? mst.ar_size  : '0;
        assign slv[k].ar_burst = grant[k] ? mst.ar_burst : '0;
        assign slv[k].ar_valid = grant[k] & mst.ar_valid;
        assign slv[k].r_ready  = grant[k] & mst.r_ready;

        assign ar_ready_s[k] = slv[k].ar_ready;
        assign r_id_s[k]     = slv[k].r_id;
        assign r_data_s[k]   = slv[k].r_data;
        assign r_resp_s[k]   = slv[k].r_resp;
        assign r_last_s[k]   = slv[k].r_last;
        assign r_valid_s[k]  = slv[k].r_valid;

        // no read request leaks to a slave that is not the lowest selected one
        a_unsel_quiet : assert property (@(posedge clk)
            (rst || !read_sel[k] || ((read_sel & LOWER) != '0))
            |-> !slv[k].ar_valid);
    end

    always_comb begin
        // default sink returns a single zero beat, always valid and last
        mst.ar_ready = 1'b1;
        mst.r_id     = DEFAULT_ID;
        mst.r_data   = DEFAULT_DATA;
        mst.r_resp   = DEFAULT_RESP;
        mst.r_last   = 1'b1;
        mst.r_valid  = 1'b1;
        for (int i = 0; i < `AXI_SLAVE_NUM; i++) begin
            if (grant[i]) begin
                mst.ar_ready = ar_ready_s[i];
                mst.r_id     = r_id_s[i];
                mst.r_data   = r_data_s[i];
                mst.r_resp   = r_resp_s[i];
                mst.r_last   = r_last_s[i];
                mst.r_valid  = r_valid_s[i];
            end
        end
    end

    // nothing selected means the master always has read data waiting
    a_sink_valid : assert property (@(posedge clk)
        (read_sel == '0) |-> mst.r_valid);

endmodule

// ==== verilog/axi_bus_top.sv ====
`timescale 1ns/1ns
`include "axi_cfg.svh"

module axi_bus_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  route_pkg::slave_sel_t                      write_sel,
    input  route_pkg::slave_sel_t                      read_sel,

    // master write path
    input  axi_pkg::id_t                               m_aw_id,
    input  axi_pkg::addr_t                             m_aw_addr,
    input  axi_pkg::len_t                              m_aw_len,
    input  axi_pkg::size_t                             m_aw_size,
    input  axi_pkg::burst_t                            m_aw_burst,
    input  logic                                       m_aw_valid,
    output logic                                       m_aw_ready,
    input  axi_pkg::data_t                             m_w_data,
    input  axi_pkg::strb_t                             m_w_strb,
    input  logic                                       m_w_last,
    input  logic                                       m_w_valid,
    output logic                                       m_w_ready,
    output axi_pkg::id_t                               m_b_id,
    output axi_pkg::resp_t                             m_b_resp,
    output logic                                       m_b_valid,
    input  logic                                       m_b_ready,

    // master read path
    input  axi_pkg::id_t                               m_ar_id,
    input  axi_pkg::addr_t                             m_ar_addr,
    input  axi_pkg::len_t                              m_ar_len,
    input  axi_pkg::size_t                             m_ar_size,
    input  axi_pkg::burst_t                            m_ar_burst,
    input  logic                                       m_ar_valid,
    output logic                                       m_ar_ready,
    output axi_pkg::id_t                               m_r_id,
    output axi_pkg::data_t                             m_r_data,
    output axi_pkg::resp_t                             m_r_resp,
    output logic                                       m_r_last,
    output logic                                       m_r_valid,
    input  logic                                       m_r_ready,

    // slave write paths, one element per slave
    output axi_pkg::id_t    [`AXI_SLAVE_NUM-1:0]       s_aw_id,
    output axi_pkg::addr_t  [`AXI_SLAVE_NUM-1:0]       s_aw_addr,
    output axi_pkg::len_t   [`AXI_SLAVE_NUM-1:0]       s_aw_len,
    output axi_pkg::size_t  [`AXI_SLAVE_NUM-1:0]       s_aw_size,
    output axi_pkg::burst_t [`AXI_SLAVE_NUM-1:0]       s_aw_burst,
    output logic            [`AXI_SLAVE_NUM-1:0]       s_aw_valid,
    input  logic            [`AXI_SLAVE_NUM-1:0]       s_aw_ready,
    output axi_pkg::data_t  [`AXI_SLAVE_NUM-1:0]       s_w_data,
    output axi_pkg::strb_t  [`AXI_SLAVE_NUM-1:0]       s_w_strb,
    output logic            [`AXI_SLAVE_NUM-1:0]       s_w_last,
    output logic            [`AXI_SLAVE_NUM-1:0]       s_w_valid,
    input  logic            [`AXI_SLAVE_NUM-1:0]       s_w_ready,
    input  axi_pkg::id_t    [`AXI_SLAVE_NUM-1:0]       s_b_id,
    input  axi_pkg::resp_t  [`AXI_SLAVE_NUM-1:0]       s_b_resp,
    input  logic            [`AXI_SLAVE_NUM-1:0]       s_b_valid,
    output logic            [`AXI_SLAVE_NUM-1:0]       s_b_ready,

    // slave read paths
    output axi_pkg::id_t    [`AXI_SLAVE_NUM-1:0]       s_ar_id,
    output axi_pkg::addr_t  [`AXI_SLAVE_NUM-1:0]       s_ar_addr,
    output axi_pkg::len_t   [`AXI_SLAVE_NUM-1:0]       s_ar_len,
    output axi_pkg::size_t  [`AXI_SLAVE_NUM-1:0]       s_ar_size,
    output axi_pkg::burst_t [`AXI_SLAVE_NUM-1:0]       s_ar_burst,
    output logic            [`AXI_SLAVE_NUM-1:0]       s_ar_valid,
    input  logic            [`AXI_SLAVE_NUM-1:0]       s_ar_ready,
    input  axi_pkg::id_t    [`AXI_SLAVE_NUM-1:0]       s_r_id,
    input  axi_pkg::data_t  [`AXI_SLAVE_NUM-1:0]       s_r_data,
    input  axi_pkg::resp_t  [`AXI_SLAVE_NUM-1:0]       s_r_resp,
    input  logic            [`AXI_SLAVE_NUM-1:0]       s_r_last,
    input  logic            [`AXI_SLAVE_NUM-1:0]       s_r_valid,
    output logic            [`AXI_SLAVE_NUM-1:0]       s_r_ready
);

    axi_write_if m_wr_bus ();
    axi_read_if  m_rd_bus ();
    axi_write_if s_wr_bus [`AXI_SLAVE_NUM] ();
    axi_read_if  s_rd_bus [`AXI_SLAVE_NUM] ();

    // master side into the bundles
    assign m_wr_bus.aw_id    = m_aw_id;
    assign m_wr_bus.aw_addr  = m_aw_addr;
    assign m_wr_bus.aw_len   = m_aw_len;
    assign m_wr_bus.aw_size  = m_aw_size;
    assign m_wr_bus.aw_burst = m_aw_burst;
    assign m_wr_bus.aw_valid = m_aw_valid;
    assign m_wr_bus.w_data   = m_w_data;
    assign m_wr_bus.w_strb   = m_w_strb;
    assign m_wr_bus.w_last   = m_w_last;
    assign m_wr_bus.w_valid  = m_w_valid;
    assign m_wr_bus.b_ready  = m_b_ready;
    assign m_aw_ready        = m_wr_bus.aw_ready;
    assign m_w_ready         = m_wr_bus.w_ready;
    assign m_b_id            = m_wr_bus.b_id;
    assign m_b_resp          = m_wr_bus.b_resp;
    assign m_b_valid         = m_wr_bus.b_valid;

    assign m_rd_bus.ar_id    = m_ar_id;
    assign m_rd_bus.ar_addr  = m_ar_addr;
    assign m_rd_bus.ar_len   = m_ar_len;
    assign m_rd_bus.ar_size  = m_ar_size;
    assign m_rd_bus.ar_burst = m_ar_burst;
    assign m_rd_bus.ar_valid = m_ar_valid;
    assign m_rd_bus.r_ready  = m_r_ready;
    assign m_ar_ready        = m_rd_bus.ar_ready;
    assign m_r_id            = m_rd_bus.r_id;
    assign m_r_data          = m_rd_bus.r_data;
    assign m_r_resp          = m_rd_bus.r_resp;
    assign m_r_last          = m_rd_bus.r_last;
    assign m_r_valid         = m_rd_bus.r_valid;

    // unpack each slave bundle onto its slice of the flat ports
    for (genvar k = 0; k < `AXI_SLAVE_NUM; k = k + 1) begin : g_port
        assign s_aw_id[k]           = s_wr_bus[k].aw_id;
        assign s_aw_addr[k]         = s_wr_bus[k].aw_addr;
        assign s_aw_len[k]          = s_wr_bus[k].aw_len;
        assign s_aw_size[k]         = s_wr_bus[k].aw_size;
        assign s_aw_burst[k]        = s_wr_bus[k].aw_burst;
        assign s_aw_valid[k]        = s_wr_bus[k].aw_valid;
        assign s_w_data[k]          = s_wr_bus[k].w_data;
        assign s_w_strb[k]          = s_wr_bus[k].w_strb;
        assign s_w_last[k]          = s_wr_bus[k].w_last;
        assign s_w_valid[k]         = s_wr_bus[k].w_valid;
        assign s_b_ready[k]         = s_wr_bus[k].b_ready;
        assign s_wr_bus[k].aw_ready = s_aw_ready[k];
        assign s_wr_bus[k].w_ready  = s_w_ready[k];
        assign s_wr_bus[k].b_id     = s_b_id[k];
        assign s_wr_bus[k].b_resp   = s_b_resp[k];
        assign s_wr_bus[k].b_valid  = s_b_valid[k];

        assign s_ar_id[k]           = s_rd_bus[k].ar_id;
        assign s_ar_addr[k]         = s_rd_bus[k].ar_addr;
        assign s_ar_len[k]          = s_rd_bus[k].ar_len;
        assign s_ar_size[k]         = s_rd_bus[k].ar_size;
        assign s_ar_burst[k]        = s_rd_bus[k].ar_burst;
        assign s_ar_valid[k]        = s_rd_bus[k].ar_valid;
        assign s_r_ready[k]         = s_rd_bus[k].r_ready;
        assign s_rd_bus[k].ar_ready = s_ar_ready[k];
        assign s_rd_bus[k].r_id     = s_r_id[k];
        assign s_rd_bus[k].r_data   = s_r_data[k];
        assign s_rd_bus[k].r_resp   = s_r_resp[k];
        assign s_rd_bus[k].r_last   = s_r_last[k];
        assign s_rd_bus[k].r_valid  = s_r_valid[k];
    end

    // write and read paths route independently
    axi_write_router u_write_router (
        .clk       (clk),
        .rst       (rst),
        .write_sel (write_sel),
        .mst       (m_wr_bus),
        .slv       (s_wr_bus)
    );

    axi_read_router u_read_router (
        .clk      (clk),
        .rst      (rst),
        .read_sel (read_sel),
        .mst      (m_rd_bus),
        .slv      (s_rd_bus)
    );

endmodule

// ==== verification/tb_axi_bus.sv ====
`timescale 1ns/1ns
`include "axi_cfg.svh"

module tb_axi_bus;

    import axi_pkg::*;
    import route_pkg::*;

    localparam int WAIT_LIMIT = 64;
    localparam int SEED = 65685;

    logic clk, rst;
    slave_sel_t write_sel, read_sel;
    id_t m_aw_id, m_ar_id, m_b_id, m_r_id;
    addr_t m_aw_addr, m_ar_addr;
    len_t m_aw_len, m_ar_len;
    size_t m_aw_size, m_ar_size;
    burst_t m_aw_burst, m_ar_burst;
    data_t m_w_data, m_r_data;
    strb_t m_w_strb;
    resp_t m_b_resp, m_r_resp;
    logic m_aw_valid, m_aw_ready, m_w_last, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
    logic m_ar_valid, m_ar_ready, m_r_last, m_r_valid, m_r_ready;
    id_t [`AXI_SLAVE_NUM-1:0] s_aw_id, s_ar_id, s_b_id, s_r_id;
    addr_t [`AXI_SLAVE_NUM-1:0] s_aw_addr, s_ar_addr;
    len_t [`AXI_SLAVE_NUM-1:0] s_aw_len, s_ar_len;
    size_t [`AXI_SLAVE_NUM-1:0] s_aw_size, s_ar_size;
    burst_t [`AXI_SLAVE_NUM-1:0] s_aw_burst, s_ar_burst;
    data_t [`AXI_SLAVE_NUM-1:0] s_w_data, s_r_data;
    strb_t [`AXI_SLAVE_NUM-1:0] s_w_strb;
    resp_t [`AXI_SLAVE_NUM-1:0] s_b_resp, s_r_resp;
    logic [`AXI_SLAVE_NUM-1:0] s_aw_valid, s_aw_ready, s_w_last, s_w_valid, s_w_ready;
    logic [`AXI_SLAVE_NUM-1:0] s_b_valid, s_b_ready;
    logic [`AXI_SLAVE_NUM-1:0] s_ar_valid, s_ar_ready, s_r_last, s_r_valid, s_r_ready;

    // bit 0 wins and reset grants nothing
    slave_sel_t exp_wr_grant, exp_rd_grant;
    int value_errors = 0;
    int timeout_errors = 0;
    int seed_init;

    assign exp_wr_grant = rst ? 2'b00 : write_sel[0] ? 2'b01 : write_sel[1] ? 2'b10 : 2'b00;
    assign exp_rd_grant = rst ? 2'b00 : read_sel[0] ? 2'b01 : read_sel[1] ? 2'b10 : 2'b00;

    axi_bus_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_value(input string name, input logic [127:0] exp_val,
                                input logic [127:0] act_val);
        value_errors++;
        $display("Fail %s expected %h actual %h", name, exp_val, act_val);
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("timed out waiting for %s", what);
    endtask

    // each slave model answers with its own id
    task automatic drive_slaves();
        for (int k = 0; k < `AXI_SLAVE_NUM; k++) begin
            s_aw_ready[k] = 1'($urandom);
            s_w_ready[k]  = 1'($urandom);
            s_b_id[k]     = (k == 0) ? 4'h5 : 4'hA;
            s_b_resp[k]   = resp_t'($urandom);
            s_b_valid[k]  = 1'($urandom);
            s_ar_ready[k] = 1'($urandom);
            s_r_id[k]     = (k == 0) ? 4'h6 : 4'hB;
            s_r_data[k]   = {$urandom, $urandom};
            s_r_resp[k]   = resp_t'($urandom);
            s_r_last[k]   = 1'($urandom);
            s_r_valid[k]  = 1'($urandom);
        end
    endtask

    task automatic drive_write_req(input slave_sel_t sel);
        write_sel  = sel;
        m_aw_id    = id_t'($urandom);
        m_aw_addr  = {$urandom, $urandom};
        m_aw_len   = len_t'($urandom);
        m_aw_size  = size_t'($urandom);
        m_aw_burst = 2'b01;
        m_aw_valid = 1'b1;
        m_w_data   = {$urandom, $urandom};
        m_w_strb   = strb_t'($urandom);
        m_w_last   = 1'b1;
        m_w_valid  = 1'b1;
    endtask

    task automatic drive_read_req(input slave_sel_t sel);
        read_sel   = sel;
        m_ar_id    = id_t'($urandom);
        m_ar_addr  = {$urandom, $urandom};
        m_ar_len   = len_t'($urandom);
        m_ar_size  = size_t'($urandom);
        m_ar_burst = 2'b01;
        m_ar_valid = 1'b1;
    endtask

    // one single-beat write burst, entered and left on a falling edge
    task automatic run_write(input slave_sel_t sel);
        bit aw_done;
        bit w_done;
        bit b_done;
        int cycles;
        aw_done = 1'b0;
        w_done = 1'b0;
        b_done = 1'b0;
        cycles = 0;
        drive_write_req(sel);
        while (!(aw_done && w_done) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            aw_done |= m_aw_valid && m_aw_ready;
            w_done |= m_w_valid && m_w_ready;
            @(negedge clk);
            if (aw_done)
                m_aw_valid = 1'b0;
            if (w_done)
                m_w_valid = 1'b0;
            cycles++;
        end
        if (!(aw_done && w_done))
            report_timeout("the AW and W handshakes");
        cycles = 0;
        while (!b_done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            b_done = m_b_valid && m_b_ready;
            @(negedge clk);
            cycles++;
        end
        if (!b_done)
            report_timeout("the B response");
    endtask

    task automatic run_read(input slave_sel_t sel);
        bit ar_done;
        bit r_done;
        int cycles;
        ar_done = 1'b0;
        r_done = 1'b0;
        cycles = 0;
        drive_read_req(sel);
        while (!ar_done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            ar_done = m_ar_valid && m_ar_ready;
            @(negedge clk);
            cycles++;
        end
        m_ar_valid = 1'b0;
        if (!ar_done)
            report_timeout("the AR handshake");
        cycles = 0;
        while (!r_done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            r_done = m_r_valid && m_r_ready && m_r_last;
            @(negedge clk);
            cycles++;
        end
        if (!r_done)
            report_timeout("the last R beat");
    endtask

    // slaves and master response readies change on the falling edge
    always @(negedge clk) begin
        drive_slaves();
        m_b_ready = 1'($urandom);
        m_r_ready = 1'($urandom);
    end

    // reset holds every slave quiet
    a_rst_quiet : assert property (@(posedge clk) rst |->
        {s_aw_valid, s_w_valid, s_ar_valid, s_b_ready, s_r_ready} == '0)
        else report_value("reset_slave_quiet", 0,
            $sampled({s_aw_valid, s_w_valid, s_ar_valid, s_b_ready, s_r_ready}));

    // default sink in reset or without a select
    a_sink_write : assert property (@(posedge clk) (rst || write_sel == '0) |->
        {m_aw_ready, m_w_ready, m_b_valid, m_b_id, m_b_resp} == {3'b111, 4'h0, RESP_OKAY})
        else report_value("sink_write", {3'b111, 4'h0, RESP_OKAY},
            $sampled({m_aw_ready, m_w_ready, m_b_valid, m_b_id, m_b_resp}));

    a_sink_read : assert property (@(posedge clk) (rst || read_sel == '0) |->
        {m_ar_ready, m_r_valid, m_r_last, m_r_id, m_r_resp, m_r_data}
        == {3'b111, 4'h0, RESP_OKAY, 64'h0})
        else report_value("sink_read", {3'b111, 4'h0, RESP_OKAY, 64'h0},
            $sampled({m_ar_ready, m_r_valid, m_r_last, m_r_id, m_r_resp, m_r_data}));

    for (genvar k = 0; k < `AXI_SLAVE_NUM; k++) begin : g_chk
        a_wr_addr : assert property (@(posedge clk) exp_wr_grant[k] |->
            {s_aw_id[k], s_aw_addr[k], s_aw_len[k], s_aw_size[k], s_aw_burst[k]}
            == {m_aw_id, m_aw_addr, m_aw_len, m_aw_size, m_aw_burst})
            else report_value($sformatf("write_addr_s%0d", k),
                $sampled({m_aw_id, m_aw_addr, m_aw_len, m_aw_size, m_aw_burst}),
                $sampled({s_aw_id[k], s_aw_addr[k], s_aw_len[k], s_aw_size[k],
                          s_aw_burst[k]}));
        a_wr_data : assert property (@(posedge clk) exp_wr_grant[k] |->
            {s_w_data[k], s_w_strb[k], s_w_last[k]} == {m_w_data, m_w_strb, m_w_last})
            else report_value($sformatf("write_data_s%0d", k),
                $sampled({m_w_data, m_w_strb, m_w_last}),
                $sampled({s_w_data[k], s_w_strb[k], s_w_last[k]}));
        a_wr_ctrl : assert property (@(posedge clk) exp_wr_grant[k] |->
            {m_aw_ready, m_w_ready, s_aw_valid[k], s_w_valid[k], s_b_ready[k], m_b_valid,
             m_b_id, m_b_resp}
            == {s_aw_ready[k], s_w_ready[k], m_aw_valid, m_w_valid, m_b_ready, s_b_valid[k],
                s_b_id[k], s_b_resp[k]})
            else report_value($sformatf("write_handshake_s%0d", k),
                $sampled({s_aw_ready[k], s_w_ready[k], m_aw_valid, m_w_valid, m_b_ready,
                          s_b_valid[k], s_b_id[k], s_b_resp[k]}),
                $sampled({m_aw_ready, m_w_ready, s_aw_valid[k], s_w_valid[k], s_b_ready[k],
                          m_b_valid, m_b_id, m_b_resp}));
        a_wr_quiet : assert property (@(posedge clk) !exp_wr_grant[k] |->
            {s_aw_valid[k], s_w_valid[k], s_b_ready[k]} == 3'b000)
            else report_value($sformatf("write_unselected_s%0d", k), 0,
                $sampled({s_aw_valid[k], s_w_valid[k], s_b_ready[k]}));
        a_rd_addr : assert property (@(posedge clk) exp_rd_grant[k] |->
            {s_ar_id[k], s_ar_addr[k], s_ar_len[k], s_ar_size[k], s_ar_burst[k]}
            == {m_ar_id, m_ar_addr, m_ar_len, m_ar_size, m_ar_burst})
            else report_value($sformatf("read_addr_s%0d", k),
                $sampled({m_ar_id, m_ar_addr, m_ar_len, m_ar_size, m_ar_burst}),
                $sampled({s_ar_id[k], s_ar_addr[k], s_ar_len[k], s_ar_size[k],
                          s_ar_burst[k]}));
        a_rd_data : assert property (@(posedge clk) exp_rd_grant[k] |->
            m_r_data == s_r_data[k])
            else report_value($sformatf("read_data_s%0d", k), $sampled(s_r_data[k]),
                $sampled(m_r_data));
        a_rd_ctrl : assert property (@(posedge clk) exp_rd_grant[k] |->
            {m_r_id, m_r_resp, m_r_last, m_r_valid, m_ar_ready, s_r_ready[k], s_ar_valid[k]}
            == {s_r_id[k], s_r_resp[k], s_r_last[k], s_r_valid[k], s_ar_ready[k], m_r_ready,
                m_ar_valid})
            else report_value($sformatf("read_handshake_s%0d", k),
                $sampled({s_r_id[k], s_r_resp[k], s_r_last[k], s_r_valid[k], s_ar_ready[k],
                          m_r_ready, m_ar_valid}),
                $sampled({m_r_id, m_r_resp, m_r_last, m_r_valid, m_ar_ready, s_r_ready[k],
                          s_ar_valid[k]}));
        a_rd_quiet : assert property (@(posedge clk) !exp_rd_grant[k] |->
            {s_ar_valid[k], s_r_ready[k]} == 2'b00)
            else report_value($sformatf("read_unselected_s%0d", k), 0,
                $sampled({s_ar_valid[k], s_r_ready[k]}));
    end

    initial begin
        seed_init = $urandom(SEED);
        rst = 1'b1;
        m_b_ready = 1'b1;
        m_r_ready = 1'b1;
        drive_slaves();
        // reset must still block live requests with both selects set
        drive_write_req(2'b11);
        drive_read_req(2'b11);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        m_aw_valid = 1'b0;
        m_w_valid = 1'b0;
        m_ar_valid = 1'b0;
        repeat (4) begin
            run_write(2'b01);
            run_read(2'b01);
            run_write(2'b10);
            run_read(2'b10);
        end
        run_write(2'b11);
        run_read(2'b11);
        run_write(2'b00);
        run_read(2'b00);
        fork
            run_write(2'b10);
            run_read(2'b01);
        join
        repeat (40) begin
            drive_write_req(slave_sel_t'($urandom));
            drive_read_req(slave_sel_t'($urandom));
            // burst kind and last bit also take both levels here
            m_aw_burst = burst_t'($urandom);
            m_ar_burst = burst_t'($urandom);
            m_w_last   = 1'($urandom);
            @(negedge clk);
        end
        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/axi_pkg.sv
verilog/route_pkg.sv
verilog/axi_write_if.sv
verilog/axi_read_if.sv
verilog/axi_write_router.sv
verilog/axi_read_router.sv
verilog/axi_bus_top.sv
verification/tb_axi_bus.sv

// ==== Bender.yml ====
package:
  name: axi_bus_router

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axi_pkg.sv
      - verilog/route_pkg.sv
      - verilog/axi_write_if.sv
      - verilog/axi_read_if.sv
      - verilog/axi_write_router.sv
      - verilog/axi_read_router.sv
      - verilog/axi_bus_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_axi_bus.sv
